/* all.f */
ifu_pkg.sv
fetch_ctrl.sv
instr_queue.sv
instr_align.sv
ifu_top.sv
tb_ifu.sv

/* fetch_ctrl.sv */
module fetch_ctrl #(
    parameter int Q_SIZE_HALF = 4,
    parameter int TXN_CNT_W   = 3
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stop_fetch_i,
    input  logic                               pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0]           pc_new_i,
    input  logic                               imem_req_ack_i,
    output logic                               imem_req_o,
    output logic [ifu_pkg::XLEN-1:0]           imem_addr_o,
    input  logic [ifu_pkg::XLEN-1:0]           imem_rdata_i,
    input  ifu_pkg::imem_resp_e                imem_resp_i,
    input  logic [$clog2(Q_SIZE_HALF/2+1)-1:0] free_words_i,
    output ifu_pkg::q_wr_t                     q_wr_o,
    output logic                               q_flush_o
);
    import ifu_pkg::*;

    typedef enum logic {
        FSM_IDLE  = 1'b0,
        FSM_FETCH = 1'b1
    } fsm_e;

    fsm_e                    fsm_ff;
    fsm_e                    fsm_next;
    logic                    flush;
    logic                    fetch_req;
    logic                    stop_req;

    logic                    resp_ok;
    logic                    resp_er;
    logic                    resp_rcvd;
    logic                    resp_vd;
    logic                    resp_er_vd;
    logic                    handshake;

    logic [XLEN-1:2]         addr_ff;
    logic [TXN_CNT_W-1:0]    pnd_cnt;
    logic [TXN_CNT_W-1:0]    pnd_cnt_next;
    logic                    pnd_full;
    logic [TXN_CNT_W-1:0]    discard_cnt;
    logic                    discard_req;
    logic [TXN_CNT_W-1:0]    vd_pnd_cnt;
    logic                    has_free_slots;

    logic                    unaligned_ff;
    q_wr_e                   wr_size;

    // ------------------------------------------------------------------------
    // Response classification
    // ------------------------------------------------------------------------
    assign resp_ok    = (imem_resp_i == IMEM_RESP_OK);
    assign resp_er    = (imem_resp_i == IMEM_RESP_ER);
    assign resp_rcvd  = resp_ok | resp_er;
    assign resp_vd    = resp_rcvd & ~discard_req;      // Belongs to current stream
    assign resp_er_vd = resp_er & ~discard_req;
    assign handshake  = imem_req_o & imem_req_ack_i;
    assign flush      = pc_new_req_i | stop_fetch_i;

    // ------------------------------------------------------------------------
    // Fetch FSM
    // ------------------------------------------------------------------------
    assign fetch_req = pc_new_req_i & ~stop_fetch_i;
    assign stop_req  = stop_fetch_i | (resp_er_vd & ~pc_new_req_i);   // Halt on fault

    always_comb begin
        case (fsm_ff)
            FSM_IDLE:  fsm_next = fetch_req ? FSM_FETCH : FSM_IDLE;
            FSM_FETCH: fsm_next = stop_req ? FSM_IDLE : FSM_FETCH;
            default:   fsm_next = FSM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= FSM_IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    // ------------------------------------------------------------------------
    // Transaction counters
    // ------------------------------------------------------------------------
    always_comb begin
        case ({handshake, resp_rcvd})
            2'b10:   pnd_cnt_next = pnd_cnt + TXN_CNT_W'(1);
            2'b01:   pnd_cnt_next = pnd_cnt - TXN_CNT_W'(1);
            default: pnd_cnt_next = pnd_cnt;           // None, or one in one out
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pnd_cnt     <= '0;
            discard_cnt <= '0;
        end else begin
            pnd_cnt <= pnd_cnt_next;
            if (flush) begin
                // Requests accepted now already use the new PC
                discard_cnt <= pnd_cnt_next - TXN_CNT_W'(handshake);
            end else if (resp_er_vd) begin
                discard_cnt <= pnd_cnt_next;           // Nothing after a fault is trusted
            end else if (resp_rcvd & discard_req) begin
                discard_cnt <= discard_cnt - TXN_CNT_W'(1);
            end
        end
    end

    assign pnd_full       = &pnd_cnt;
    assign discard_req    = |discard_cnt;
    assign vd_pnd_cnt     = pnd_cnt - discard_cnt;
    assign has_free_slots = (free_words_i > vd_pnd_cnt);   // Room for every live reply

    // ------------------------------------------------------------------------
    // Memory request and word address
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
        end else if (pc_new_req_i) begin
            addr_ff <= pc_new_i[XLEN-1:2] + (XLEN-2)'(handshake);
        end else if (handshake) begin
            addr_ff <= addr_ff + (XLEN-2)'(1);     // Next word
        end
    end

    assign imem_req_o  = (pc_new_req_i & ~stop_fetch_i & ~pnd_full)
                       | ((fsm_ff == FSM_FETCH) & ~stop_fetch_i & ~pnd_full & has_free_slots);
    assign imem_addr_o = pc_new_req_i ? {pc_new_i[XLEN-1:2], 2'b00} : {addr_ff, 2'b00};

    // ------------------------------------------------------------------------
    // Queue write decode
    // ------------------------------------------------------------------------
    always_comb begin
        wr_size = Q_WR_NONE;
        if (resp_vd) begin
            // Skip half before the PC, faulty word flagged on both halves
            wr_size = unaligned_ff ? Q_WR_HI : Q_WR_FULL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unaligned_ff <= 1'b0;
        end else if (pc_new_req_i) begin
            unaligned_ff <= pc_new_i[1];
        end else if (resp_vd) begin
            unaligned_ff <= 1'b0;                   // Only the first word is partial
        end
    end

    always_comb begin
        q_wr_o.size = wr_size;
        q_wr_o.hi   = imem_rdata_i[XLEN-1:HWORD_W];
        q_wr_o.lo   = imem_rdata_i[HWORD_W-1:0];
        q_wr_o.err  = resp_er;
    end

    assign q_flush_o = flush;

endmodule

/* ifu_pkg.sv */
package ifu_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int XLEN    = 32;           // Address and instruction word
    localparam int HWORD_W = 16;           // Queue entry, one halfword

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------

    // Memory response code, one per accepted request, in order
    typedef enum logic [1:0] {
        IMEM_RESP_IDLE = 2'b00,            // No response this cycle
        IMEM_RESP_OK   = 2'b01,            // Read data valid
        IMEM_RESP_ER   = 2'b10             // Access fault
    } imem_resp_e;

    // Queue write size
    typedef enum logic [1:0] {
        Q_WR_NONE = 2'b00,
        Q_WR_FULL = 2'b01,                 // Both halfwords, low first
        Q_WR_HI   = 2'b10                  // Upper halfword only
    } q_wr_e;

    // Queue read size
    typedef enum logic [1:0] {
        Q_RD_NONE  = 2'b00,
        Q_RD_HWORD = 2'b01,                // RVC or faulty head
        Q_RD_WORD  = 2'b10                 // RVI, two halfwords
    } q_rd_e;

    // ------------------------------------------------------------------------
    // Stage to stage bundles
    // ------------------------------------------------------------------------

    // Producer to queue, one write per response
    typedef struct packed {
        q_wr_e                size;
        logic [HWORD_W-1:0]   hi;          // rdata[31:16]
        logic [HWORD_W-1:0]   lo;          // rdata[15:0]
        logic                 err;         // Response carried an error
    } q_wr_t;

    // Queue head as seen by the aligner
    typedef struct packed {
        logic                 empty;
        logic                 one_hw;      // Exactly one halfword held
        logic [HWORD_W-1:0]   head;
        logic [HWORD_W-1:0]   next;
        logic                 head_err;
        logic                 next_err;
    } q_head_t;

endpackage

/* ifu_top.sv */
module ifu_top #(
    parameter int Q_SIZE_HALF = 4,     // Halfwords, power of two, 4 or more
    parameter int TXN_CNT_W   = 3      // Outstanding reads up to 2**W - 1
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Pipeline control
    input  logic                       stop_fetch_i,
    input  logic                       pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0]   pc_new_i,

    // Instruction memory
    input  logic                       imem_req_ack_i,
    output logic                       imem_req_o,
    output logic [ifu_pkg::XLEN-1:0]   imem_addr_o,
    input  logic [ifu_pkg::XLEN-1:0]   imem_rdata_i,
    input  ifu_pkg::imem_resp_e        imem_resp_i,

    // Decoder
    input  logic                       idu_rdy_i,
    output logic                       idu_vd_o,
    output logic [ifu_pkg::XLEN-1:0]   idu_instr_o,
    output logic                       idu_imem_err_o,
    output logic                       idu_err_rvi_hi_o
);
    import ifu_pkg::*;

    localparam int FREE_W_W = $clog2(Q_SIZE_HALF/2 + 1);

    q_wr_t                 q_wr;
    logic                  q_flush;
    q_rd_e                 q_rd;
    q_head_t               q_head;
    logic [FREE_W_W-1:0]   free_words;

    // Producer
    fetch_ctrl #(
        .Q_SIZE_HALF (Q_SIZE_HALF),
        .TXN_CNT_W   (TXN_CNT_W)
    ) u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .stop_fetch_i   (stop_fetch_i),
        .pc_new_req_i   (pc_new_req_i),
        .pc_new_i       (pc_new_i),
        .imem_req_ack_i (imem_req_ack_i),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .imem_resp_i    (imem_resp_i),
        .free_words_i   (free_words),
        .q_wr_o         (q_wr),
        .q_flush_o      (q_flush)
    );

    // Halfword buffer
    instr_queue #(
        .Q_SIZE_HALF (Q_SIZE_HALF)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .q_wr_i       (q_wr),
        .q_flush_i    (q_flush),
        .q_rd_i       (q_rd),
        .q_head_o     (q_head),
        .free_words_o (free_words)
    );

    // Consumer, combinational
    instr_align u_align (
        .q_head_i         (q_head),
        .idu_rdy_i        (idu_rdy_i),
        .q_rd_o           (q_rd),
        .idu_vd_o         (idu_vd_o),
        .idu_instr_o      (idu_instr_o),
        .idu_imem_err_o   (idu_imem_err_o),
        .idu_err_rvi_hi_o (idu_err_rvi_hi_o)
    );

endmodule

/* instr_align.sv */
module instr_align (
    input  ifu_pkg::q_head_t           q_head_i,
    input  logic                       idu_rdy_i,
    output ifu_pkg::q_rd_e             q_rd_o,
    output logic                       idu_vd_o,
    output logic [ifu_pkg::XLEN-1:0]   idu_instr_o,
    output logic                       idu_imem_err_o,
    output logic                       idu_err_rvi_hi_o
);
    import ifu_pkg::*;

    logic head_is_rvi;
    logic single_hw;                   // Head leaves as one halfword

    // ------------------------------------------------------------------------
    // Length decode
    // ------------------------------------------------------------------------
    assign head_is_rvi = &q_head_i.head[1:0];
    assign single_hw   = ~head_is_rvi | q_head_i.head_err;   // Faulty head goes alone

    // ------------------------------------------------------------------------
    // Valid and error flags
    // ------------------------------------------------------------------------
    always_comb begin
        idu_vd_o         = 1'b0;
        idu_imem_err_o   = 1'b0;
        idu_err_rvi_hi_o = 1'b0;
        if (!q_head_i.empty) begin
            if (q_head_i.one_hw) begin
                // RVI waits for its upper half
                idu_vd_o       = single_hw;
                idu_imem_err_o = q_head_i.head_err;
            end else begin
                idu_vd_o         = 1'b1;
                idu_imem_err_o   = q_head_i.head_err | (head_is_rvi & q_head_i.next_err);
                idu_err_rvi_hi_o = ~q_head_i.head_err & head_is_rvi & q_head_i.next_err;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Instruction mux and queue read size
    // ------------------------------------------------------------------------
    assign idu_instr_o = single_hw ? XLEN'(q_head_i.head)          // Zero extended
                                   : {q_head_i.next, q_head_i.head};

    always_comb begin
        if (idu_vd_o & idu_rdy_i) begin
            q_rd_o = single_hw ? Q_RD_HWORD : Q_RD_WORD;
        end else begin
            q_rd_o = Q_RD_NONE;                          // Hold head under back-pressure
        end
    end

endmodule

/* instr_queue.sv */
module instr_queue #(
    parameter int Q_SIZE_HALF = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  ifu_pkg::q_wr_t                     q_wr_i,
    input  logic                               q_flush_i,
    input  ifu_pkg::q_rd_e                     q_rd_i,
    output ifu_pkg::q_head_t                   q_head_o,
    output logic [$clog2(Q_SIZE_HALF/2+1)-1:0] free_words_o
);
    import ifu_pkg::*;

    localparam int ADR_W    = $clog2(Q_SIZE_HALF);
    localparam int PTR_W    = ADR_W + 1;           // Extra bit tells full from empty
    localparam int FREE_W_W = $clog2(Q_SIZE_HALF/2 + 1);

    logic [HWORD_W-1:0]  q_data [Q_SIZE_HALF];
    logic                q_err  [Q_SIZE_HALF];

    logic [PTR_W-1:0]    wptr;
    logic [PTR_W-1:0]    rptr;
    logic [PTR_W-1:0]    rptr_adv;
    logic [PTR_W-1:0]    rptr_nxt_ent;
    logic [PTR_W-1:0]    ocpd_h;
    logic [PTR_W-1:0]    free_h_next;
    logic                wr_en;
    logic                wr_full;
    logic                rd_en;

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------
    assign wr_en   = (q_wr_i.size != Q_WR_NONE) & ~q_flush_i;   // Flush wins
    assign wr_full = (q_wr_i.size == Q_WR_FULL);
    assign rd_en   = (q_rd_i != Q_RD_NONE);

    assign rptr_adv = rd_en ? rptr + ((q_rd_i == Q_RD_HWORD) ? PTR_W'(1) : PTR_W'(2))
                            : rptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else if (q_flush_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            rptr <= rptr_adv;
            if (wr_en) begin
                wptr <= wptr + (wr_full ? PTR_W'(2) : PTR_W'(1));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_full) begin
                q_data[ADR_W'(wptr)]             <= q_wr_i.lo;
                q_err[ADR_W'(wptr)]              <= q_wr_i.err;
                q_data[ADR_W'(wptr + PTR_W'(1))] <= q_wr_i.hi;
                q_err[ADR_W'(wptr + PTR_W'(1))]  <= q_wr_i.err;
            end else begin
                q_data[ADR_W'(wptr)] <= q_wr_i.hi;    // Upper half lands at head side
                q_err[ADR_W'(wptr)]  <= q_wr_i.err;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Status toward the aligner and the producer
    // ------------------------------------------------------------------------
    assign rptr_nxt_ent = rptr + PTR_W'(1);
    assign ocpd_h       = wptr - rptr;

    always_comb begin
        q_head_o.empty    = (wptr == rptr);
        q_head_o.one_hw   = (ocpd_h == PTR_W'(1));
        q_head_o.head     = q_data[ADR_W'(rptr)];
        q_head_o.next     = q_data[ADR_W'(rptr_nxt_ent)];
        q_head_o.head_err = q_err[ADR_W'(rptr)];
        q_head_o.next_err = q_err[ADR_W'(rptr_nxt_ent)];
    end

    // Space left once this cycle's read has drained
    assign free_h_next  = PTR_W'(Q_SIZE_HALF) - (wptr - rptr_adv);
    assign free_words_o = FREE_W_W'(free_h_next >> 1);   // Whole words only

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" \
    && verilator --binary --assert -Wno-fatal --top-module tb_ifu -f all.f -o tb_ifu \
    && ./obj_dir/tb_ifu | tee /dev/stderr | grep "Test passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation FAILED"; exit 1; }

/* tb_ifu.sv */
module tb_ifu;
    import ifu_pkg::*;

    localparam int Q_SIZE_HALF = 4;
    localparam int TXN_CNT_W   = 3;
    localparam int MEM_WORDS   = 64;
    localparam int N_ROWS      = 8;
    localparam int MAX_WAIT    = 2000;          // Cycles per row

    // One stimulus row
    typedef struct packed {
        logic [31:0] pc;                        // Start PC
        logic [7:0]  n_chk;                     // Instructions to check
        logic [7:0]  redir_at;                  // Redirect cycle, 0 for none
        logic [31:0] pc2;                       // Redirect target
        logic        stop;                      // Stop-fetch after the stream
        logic [7:0]  rdy_pct;                   // Decoder ready rate, percent
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         stop_fetch;
    logic         pc_new_req;
    logic [31:0]  pc_new;
    logic         imem_ack;
    logic         imem_req;
    logic [31:0]  imem_addr;
    logic [31:0]  imem_rdata;
    imem_resp_e   imem_resp;
    logic         idu_rdy;
    logic         idu_vd;
    logic [31:0]  idu_instr;
    logic         idu_err;
    logic         idu_err_hi;

    row_t         rows [N_ROWS];
    logic [31:0]  mem_data [MEM_WORDS];         // Memory image
    logic         mem_err  [MEM_WORDS];         // Fault per word
    int           pnd_word [$];                 // Accepted reads, oldest first
    int           pnd_due  [$];
    int           pnd_at_sample;
    int           cyc;

    logic [31:0]  exp_instr [64];
    logic         exp_err   [64];
    logic         exp_hi    [64];
    int           exp_len;
    int           got_cnt;
    logic         collecting;
    logic         req_locked;                   // Set once a fault is consumed
    logic         hold_vd;
    logic [31:0]  hold_instr;
    logic         hold_err;
    logic         hold_hi;

    ifu_top #(
        .Q_SIZE_HALF (Q_SIZE_HALF),
        .TXN_CNT_W   (TXN_CNT_W)
    ) i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .stop_fetch_i     (stop_fetch),
        .pc_new_req_i     (pc_new_req),
        .pc_new_i         (pc_new),
        .imem_req_ack_i   (imem_ack),
        .imem_req_o       (imem_req),
        .imem_addr_o      (imem_addr),
        .imem_rdata_i     (imem_rdata),
        .imem_resp_i      (imem_resp),
        .idu_rdy_i        (idu_rdy),
        .idu_vd_o         (idu_vd),
        .idu_instr_o      (idu_instr),
        .idu_imem_err_o   (idu_err),
        .idu_err_rvi_hi_o (idu_err_hi)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what, input int row_idx);
        $display("timeout waiting for %s in row %0d", what, row_idx);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference stream from the image
    // ------------------------------------------------------------------------
    function automatic logic [15:0] hw_at(input int h);
        logic [31:0] w;
        w = mem_data[(h / 2) % MEM_WORDS];
        return ((h % 2) == 1) ? w[31:16] : w[15:0];
    endfunction

    function automatic logic hw_err(input int h);
        return mem_err[(h / 2) % MEM_WORDS];
    endfunction

    // Walk halfwords from the PC, stop after n or at the first fault
    function automatic void build_expected(input logic [31:0] pc, input int n);
        int          h;
        logic [15:0] first;
        logic        last;
        h       = int'(pc[31:1]);
        exp_len = 0;
        last    = 1'b0;
        while (exp_len < n && !last) begin
            first = hw_at(h);
            if (hw_err(h)) begin
                exp_instr[exp_len] = {16'h0000, first};     // Faulty head alone
                exp_err[exp_len]   = 1'b1;
                exp_hi[exp_len]    = 1'b0;
                h = h + 1;
            end else if (first[1:0] == 2'b11) begin
                exp_instr[exp_len] = {hw_at(h + 1), first};
                exp_err[exp_len]   = hw_err(h + 1);
                exp_hi[exp_len]    = hw_err(h + 1);         // Only upper half failed
                h = h + 2;
            end else begin
                exp_instr[exp_len] = {16'h0000, first};
                exp_err[exp_len]   = 1'b0;
                exp_hi[exp_len]    = 1'b0;
                h = h + 1;
            end
            last = exp_err[exp_len];
            exp_len++;
        end
    endfunction

    // ------------------------------------------------------------------------
    // One clock cycle: memory model, decoder model, checks
    // ------------------------------------------------------------------------
    task automatic run_cycle(input logic new_pc, input logic [31:0] pc,
                             input logic stop, input int rdy_pct);
        int widx;
        @(negedge clk);
        cyc++;
        if (pnd_due.size() > 0 && pnd_due[0] <= cyc) begin
            widx       = pnd_word.pop_front();
            void'(pnd_due.pop_front());
            imem_rdata = mem_data[widx];
            imem_resp  = mem_err[widx] ? IMEM_RESP_ER : IMEM_RESP_OK;
        end else begin
            imem_rdata = $urandom;                  // Junk on idle bus
            imem_resp  = IMEM_RESP_IDLE;
        end
        imem_ack   = ($urandom_range(99) < 60) && (pnd_word.size() < 7);
        idu_rdy    = ($urandom_range(99) < rdy_pct);
        pc_new_req = new_pc;
        pc_new     = pc;
        stop_fetch = stop;
        if (new_pc) req_locked = 1'b0;
        #10;                                        // Outputs settled
        pnd_at_sample = pnd_word.size();
        if (req_locked) check_value("imem_req_o", 32'(imem_req), 32'h0);
        if (imem_req) begin
            check_value("imem_addr_o[1:0]", 32'(imem_addr[1:0]), 32'h0);
            if (imem_ack) begin
                pnd_word.push_back(int'(imem_addr[7:2]));
                pnd_due.push_back(cyc + int'($urandom_range(3, 1)));
            end
        end
        // Held instruction must not move under back-pressure
        if (hold_vd) begin
            check_value("idu_vd_o", 32'(idu_vd), 32'h1);
            check_value("idu_instr_o", idu_instr, hold_instr);
            check_value("idu_imem_err_o", 32'(idu_err), 32'(hold_err));
            check_value("idu_err_rvi_hi_o", 32'(idu_err_hi), 32'(hold_hi));
        end
        hold_vd    = idu_vd && !idu_rdy && !new_pc && !stop;
        hold_instr = idu_instr;
        hold_err   = idu_err;
        hold_hi    = idu_err_hi;
        if (idu_vd && idu_rdy && collecting && got_cnt < exp_len) begin
            check_value("idu_instr_o", idu_instr, exp_instr[got_cnt]);
            check_value("idu_imem_err_o", 32'(idu_err), 32'(exp_err[got_cnt]));
            check_value("idu_err_rvi_hi_o", 32'(idu_err_hi), 32'(exp_hi[got_cnt]));
            if (idu_err) req_locked = 1'b1;
            got_cnt++;
        end
    endtask

    task automatic fill_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_data[i] = $urandom;
            mem_err[i]  = 1'b0;
        end
        mem_data[38] = mem_data[38] & 32'hFFFC_FFFC;            // RVC only
        mem_data[39] = mem_data[39] & 32'hFFFC_FFFC;
        mem_err[40]  = 1'b1;                                    // Fault on a head
        mem_data[48] = mem_data[48] & 32'hFFFC_FFFC;
        mem_data[49] = (mem_data[49] & 32'hFFFF_FFFC) | 32'h0003_0000;
        mem_err[50]  = 1'b1;                                    // Fault on RVI upper half
    endtask

    // pc, n_chk, redir_at, pc2, stop, rdy_pct
    task automatic fill_table();
        rows[0] = '{32'h0000_0000, 8'd24, 8'd0, 32'h0, 1'b0, 8'd100};  // Aligned mix
        rows[1] = '{32'h0000_0012, 8'd16, 8'd0, 32'h0, 1'b0, 8'd80};   // Unaligned start
        rows[2] = '{32'h0000_0040, 8'd20, 8'd0, 32'h0, 1'b0, 8'd25};   // Back-pressure
        rows[3] = '{32'h0000_0020, 8'd12, 8'd7, 32'h0000_0006, 1'b0, 8'd90};
        rows[4] = '{32'h0000_0098, 8'd40, 8'd0, 32'h0, 1'b0, 8'd70};   // Head fault
        rows[5] = '{32'h0000_00C0, 8'd40, 8'd0, 32'h0, 1'b0, 8'd70};   // Upper half fault
        rows[6] = '{32'h0000_0030, 8'd14, 8'd0, 32'h0, 1'b1, 8'd60};   // Stop-fetch
        rows[7] = '{32'h0000_00E6, 8'd20, 8'd0, 32'h0, 1'b0, 8'd100};  // Wraps the image
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int   r;
        int   i;
        int   waited;
        logic redir_ok;
        row_t row;
        rst_n      = 1'b0;
        stop_fetch = 1'b0;
        pc_new_req = 1'b0;
        pc_new     = '0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        imem_resp  = IMEM_RESP_IDLE;
        idu_rdy    = 1'b0;
        cyc        = 0;
        got_cnt    = 0;
        exp_len    = 0;
        collecting = 1'b0;
        req_locked = 1'b0;
        hold_vd    = 1'b0;
        void'($urandom(94834));
        fill_image();
        fill_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #10;
        check_value("imem_req_o", 32'(imem_req), 32'h0);        // Idle out of reset
        check_value("idu_vd_o", 32'(idu_vd), 32'h0);
        check_value("idu_imem_err_o", 32'(idu_err), 32'h0);
        check_value("idu_err_rvi_hi_o", 32'(idu_err_hi), 32'h0);

        for (r = 0; r < N_ROWS; r++) begin
            row        = rows[r];
            collecting = 1'b0;                      // Old head may leave this cycle
            run_cycle(1'b1, row.pc, 1'b0, int'(row.rdy_pct));
            if (pnd_at_sample < 6) check_value("imem_req_o", 32'(imem_req), 32'h1);
            if (imem_req) check_value("imem_addr_o", imem_addr, {row.pc[31:2], 2'b00});
            build_expected(row.pc, int'(row.n_chk));
            got_cnt    = 0;
            collecting = 1'b1;
            waited     = 0;
            redir_ok   = (row.redir_at == 8'd0);
            while (got_cnt < exp_len || !redir_ok) begin
                if (waited >= MAX_WAIT) report_timeout("instructions", r);
                waited++;
                if (!redir_ok && waited == int'(row.redir_at)) begin
                    run_cycle(1'b1, row.pc2, 1'b0, int'(row.rdy_pct));
                    build_expected(row.pc2, int'(row.n_chk));   // Old stream is stale now
                    got_cnt  = 0;
                    redir_ok = 1'b1;
                end else begin
                    run_cycle(1'b0, row.pc, 1'b0, int'(row.rdy_pct));
                end
            end
            collecting = 1'b0;
            // After a fault the request stays low, checked inside run_cycle
            if (exp_err[exp_len-1]) begin
                for (i = 0; i < 20; i++) run_cycle(1'b0, row.pc, 1'b0, int'(row.rdy_pct));
            end
            if (row.stop) begin
                for (i = 0; i < 10; i++) begin
                    run_cycle(1'b0, row.pc, 1'b1, int'(row.rdy_pct));
                    check_value("imem_req_o", 32'(imem_req), 32'h0);
                    if (i > 0) check_value("idu_vd_o", 32'(idu_vd), 32'h0);
                end
                for (i = 0; i < 4; i++) begin
                    run_cycle(1'b0, row.pc, 1'b0, int'(row.rdy_pct));
                    check_value("imem_req_o", 32'(imem_req), 32'h0);   // Waits for new PC
                    check_value("idu_vd_o", 32'(idu_vd), 32'h0);
                end
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule
